// File: Bender.yml
package:
  name: uart_top

sources:
  - target: rtl
    files:
      - hw/uart_pkg.sv
      - hw/uart_link_if.sv
      - hw/uart_regs.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/uart_top.sv
  - target: test
    files:
      - testbench/uart_tb.sv

// File: hw/uart_link_if.sv
interface uart_link_if;

   // configuration and commands from the register block
   logic [uart_pkg::div_w-1:0]  divider;
   logic                        tx_en;
   logic                        rx_en;
   logic                        clear;
   logic                        tx_load;
   logic [uart_pkg::byte_w-1:0] tx_byte;
   logic                        rx_take;

   // status back from the engines
   logic                        tx_busy;
   logic [uart_pkg::byte_w-1:0] rx_byte;
   logic                        rx_valid;
   logic                        rts_req;

   modport regs (
      output divider, tx_en, rx_en, clear, tx_load, tx_byte, rx_take,
      input  tx_busy, rx_byte, rx_valid, rts_req
   );

   modport tx (
      input  divider, tx_en, clear, tx_load, tx_byte,
      output tx_busy
   );

   modport rx (
      input  divider, clear, rx_take,
      output rx_byte, rx_valid, rts_req
   );

endinterface

// File: hw/uart_pkg.sv
package uart_pkg;

   //////////////////////////////////////////////////////////////////////
   // bus and datapath widths
   //////////////////////////////////////////////////////////////////////

   localparam int data_w = 32;
   localparam int addr_w = 3;
   localparam int div_w  = 16;
   localparam int byte_w = 8;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////

   localparam logic [addr_w-1:0] addr_write_wait = 3'd0;
   localparam logic [addr_w-1:0] addr_div        = 3'd1;
   localparam logic [addr_w-1:0] addr_data       = 3'd2;
   localparam logic [addr_w-1:0] addr_tx_en      = 3'd3;
   localparam logic [addr_w-1:0] addr_read_valid = 3'd4;
   localparam logic [addr_w-1:0] addr_soft_reset = 3'd5;
   localparam logic [addr_w-1:0] addr_rx_en      = 3'd6;

   // divider value out of reset
   localparam logic [div_w-1:0] div_reset = 16'd1;

   // one bus write word seen either as a divider or as byte plus flag
   typedef union packed {
      logic [data_w-1:0] word;
      struct packed {
         logic [data_w-byte_w-2:0] pad;
         logic [byte_w-1:0]        data;
         logic                     flag;
      } ctrl;
   } uart_word_u;

endpackage

// File: hw/uart_regs.sv
module uart_regs (
   input  logic                        clk,
   input  logic                        rst_int,
   input  logic                        valid,
   input  logic [uart_pkg::addr_w-1:0] address,
   input  logic [uart_pkg::data_w-1:0] wdata,
   input  logic                        wstrb,
   input  logic                        cts,
   output logic [uart_pkg::data_w-1:0] rdata,
   output logic                        ready,
   output logic                        rts,
   uart_link_if.regs                   link
);

   uart_pkg::uart_word_u        wdata_u;
   logic                        div_we;
   logic                        data_we;
   logic                        tx_en_we;
   logic                        rx_en_we;
   logic                        soft_we;
   logic [uart_pkg::addr_w-1:0] address_q;
   logic                        wstrb_q;
   logic [1:0]                  cts_sync;

   assign wdata_u = wdata;

   //////////////////////////////////////////////////////////////////////
   // write decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      div_we   = 1'b0;
      data_we  = 1'b0;
      tx_en_we = 1'b0;
      rx_en_we = 1'b0;
      soft_we  = 1'b0;
      if (valid && wstrb) begin
         case (address)
            uart_pkg::addr_div:        div_we   = 1'b1;
            uart_pkg::addr_data:       data_we  = 1'b1;
            uart_pkg::addr_tx_en:      tx_en_we = 1'b1;
            uart_pkg::addr_rx_en:      rx_en_we = 1'b1;
            uart_pkg::addr_soft_reset: soft_we  = 1'b1;
            default: ;
         endcase
      end
   end

   // transmit request goes straight to the engine
   assign link.tx_load = data_we;
   assign link.tx_byte = wdata_u.ctrl.data;

   // reading the data register frees the receive buffer
   assign link.rx_take = valid && !wstrb && (address == uart_pkg::addr_data);

   // one cycle soft reset pulse
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         link.clear <= 1'b0;
      else
         link.clear <= soft_we && wdata_u.ctrl.flag;
   end

   //////////////////////////////////////////////////////////////////////
   // configuration
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         link.divider <= uart_pkg::div_reset;
         link.tx_en   <= 1'b0;
         link.rx_en   <= 1'b0;
      end else if (link.clear) begin
         link.divider <= uart_pkg::div_reset;
         link.tx_en   <= 1'b0;
         link.rx_en   <= 1'b0;
      end else begin
         if (div_we)
            link.divider <= wdata_u.word[uart_pkg::div_w-1:0];
         if (tx_en_we)
            link.tx_en <= wdata_u.ctrl.flag;
         if (rx_en_we)
            link.rx_en <= wdata_u.ctrl.flag;
      end
   end

   // cts synchronizer idles high
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         cts_sync <= 2'b11;
      else
         cts_sync <= {cts_sync[0], cts};
   end

   assign rts = link.rts_req && link.rx_en;

   //////////////////////////////////////////////////////////////////////
   // bus response
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         ready <= 1'b0;
      else
         ready <= valid;
   end

   // access info for the ready cycle
   always_ff @(posedge clk) begin
      address_q <= address;
      wstrb_q   <= wstrb;
   end

   always_comb begin
      rdata = '0;
      if (ready && !wstrb_q) begin
         case (address_q)
            uart_pkg::addr_write_wait:
               rdata[0] = link.tx_busy || !cts_sync[1];
            uart_pkg::addr_div:
               rdata = {{(uart_pkg::data_w - uart_pkg::div_w){1'b0}}, link.divider};
            uart_pkg::addr_data:
               rdata = {{(uart_pkg::data_w - uart_pkg::byte_w){1'b0}}, link.rx_byte};
            uart_pkg::addr_read_valid:
               rdata[0] = link.rx_valid;
            default: ;
         endcase
      end
   end

endmodule

// File: hw/uart_rx.sv
module uart_rx (
   input  logic   clk,
   input  logic   rst_int,
   input  logic   rxd,
   uart_link_if.rx link
);

   logic [3:0]                  state;
   logic [uart_pkg::div_w-1:0]  cnt;
   logic [uart_pkg::byte_w-1:0] pattern;
   logic                        half_done;
   logic                        bit_done;
   logic                        sample;
   logic                        finish;

   // twice the count reaches the divider at mid start bit
   assign half_done = ({cnt, 1'b0} >= {1'b0, link.divider});
   assign bit_done  = (cnt >= link.divider);
   assign sample    = (state inside {[4'd2:4'd9]}) && bit_done;
   assign finish    = (state == 4'd10) && (cnt == link.divider);

   //////////////////////////////////////////////////////////////////////
   // receive FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state         <= 4'd0;
         cnt           <= '0;
         link.rx_valid <= 1'b0;
         link.rts_req  <= 1'b1;
      end else if (link.clear) begin
         state         <= 4'd0;
         cnt           <= '0;
         link.rx_valid <= 1'b0;
         link.rts_req  <= 1'b1;
      end else begin
         cnt <= cnt + 16'd1;
         // buffer read by the processor
         if (link.rx_take) begin
            link.rx_valid <= 1'b0;
            link.rts_req  <= 1'b1;
         end
         case (state)
            // idle until a start bit
            4'd0: begin
               cnt <= 16'd1;
               if (!rxd) begin
                  state        <= 4'd1;
                  link.rts_req <= 1'b0;
               end
            end
            // move to middle of start bit
            4'd1: begin
               if (half_done) begin
                  state <= 4'd2;
                  cnt   <= 16'd1;
               end
            end
            // one period past the last data bit
            4'd10: begin
               if (finish) begin
                  link.rx_valid <= 1'b1;
                  state         <= 4'd0;
               end
            end
            // data bits LSB first
            default: begin
               if (bit_done) begin
                  state <= state + 4'd1;
                  cnt   <= 16'd1;
               end
            end
         endcase
      end
   end

   // shift register and receive buffer
   always_ff @(posedge clk) begin
      if (sample)
         pattern <= {rxd, pattern[uart_pkg::byte_w-1:1]};
      if (finish)
         link.rx_byte <= pattern;
   end

endmodule

// File: hw/uart_top.sv
module uart_top (
   input  logic                        clk,
   input  logic                        rst_int,
   // processor bus
   input  logic                        valid,
   input  logic [uart_pkg::addr_w-1:0] address,
   input  logic [uart_pkg::data_w-1:0] wdata,
   input  logic                        wstrb,
   output logic [uart_pkg::data_w-1:0] rdata,
   output logic                        ready,
   // serial line
   output logic                        txd,
   input  logic                        rxd,
   input  logic                        cts,
   output logic                        rts
);

   uart_link_if link ();

   uart_regs i_regs (
      .clk     (clk),
      .rst_int (rst_int),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .cts     (cts),
      .rdata   (rdata),
      .ready   (ready),
      .rts     (rts),
      .link    (link.regs)
   );

   uart_tx i_tx (
      .clk     (clk),
      .rst_int (rst_int),
      .link    (link.tx),
      .txd     (txd)
   );

   uart_rx i_rx (
      .clk     (clk),
      .rst_int (rst_int),
      .rxd     (rxd),
      .link    (link.rx)
   );

endmodule

// File: hw/uart_tx.sv
module uart_tx (
   input  logic   clk,
   input  logic   rst_int,
   uart_link_if.tx link,
   output logic   txd
);

   logic [uart_pkg::div_w-1:0] baud_cnt;
   logic [3:0]                 bit_cnt;
   logic [9:0]                 shift_q;
   logic                       wrap;

   // end of one bit period
   assign wrap = (baud_cnt == link.divider);

   // baud counter runs 1..divider
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         baud_cnt <= '0;
      else if (link.clear)
         baud_cnt <= '0;
      else if (link.tx_load || wrap)
         baud_cnt <= 16'd1;
      else if (baud_cnt != '0)
         baud_cnt <= baud_cnt + 16'd1;
   end

   // bits left in the frame
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         bit_cnt <= 4'd0;
      else if (link.clear)
         bit_cnt <= 4'd0;
      else if (link.tx_load)
         bit_cnt <= 4'd10;
      else if (bit_cnt != 4'd0 && wrap)
         bit_cnt <= bit_cnt - 4'd1;
   end

   // stop, data, start; line idles high
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         shift_q <= '1;
      else if (link.clear)
         shift_q <= '1;
      else if (link.tx_load)
         shift_q <= {1'b1, link.tx_byte, 1'b0};
      else if (bit_cnt != 4'd0 && wrap)
         shift_q <= {1'b1, shift_q[9:1]};
   end

   assign link.tx_busy = (bit_cnt != 4'd0);

   // held at mark while disabled
   assign txd = shift_q[0] || !link.tx_en;

endmodule

// File: testbench/uart_tb.sv
module uart_tb;

   localparam int div_test    = 8;
   localparam int cycle_limit = 12 * 10 * div_test + 2000;
   localparam int poll_limit  = 100;

   logic                        clk, rst_int, valid, wstrb, rxd, cts;
   logic                        ready, txd, rts;
   logic [uart_pkg::addr_w-1:0] address;
   logic [uart_pkg::data_w-1:0] wdata, rdata;
   integer                      seed = 32'h20e1;
   int                          value_errs = 0;
   int                          other_errs = 0;
   int                          cycles = 0;

   uart_top i_dut (
      .clk (clk), .rst_int (rst_int), .valid (valid), .address (address),
      .wdata (wdata), .wstrb (wstrb), .rdata (rdata), .ready (ready),
      .txd (txd), .rxd (rxd), .cts (cts), .rts (rts)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // run limit from the longest expected test sequence
   initial begin
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input logic [uart_pkg::data_w-1:0] exp,
                             input logic [uart_pkg::data_w-1:0] act);
      if (act !== exp) begin
         value_errs++;
         $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input logic [uart_pkg::byte_w-1:0] exp,
                             input logic [uart_pkg::byte_w-1:0] act);
      if (act !== exp) begin
         value_errs++;
         $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         value_errs++;
         $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // bus and serial tasks
   //////////////////////////////////////////////////////////////////////

   // one access; ready must come exactly one cycle after valid
   task automatic bus_cycle(input logic [uart_pkg::addr_w-1:0] addr,
                            input logic [uart_pkg::data_w-1:0] data, input logic write,
                            output logic [uart_pkg::data_w-1:0] rd);
      @(posedge clk);
      valid   <= 1'b1;
      address <= addr;
      wdata   <= data;
      wstrb   <= write;
      @(negedge clk);
      check_bit("ready", 1'b0, ready);
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= 1'b0;
      @(negedge clk);
      check_bit("ready", 1'b1, ready);
      rd = rdata;
   endtask

   task automatic bus_write(input logic [uart_pkg::addr_w-1:0] addr,
                            input logic [uart_pkg::data_w-1:0] data);
      logic [uart_pkg::data_w-1:0] unused;
      bus_cycle(addr, data, 1'b1, unused);
   endtask

   task automatic bus_read(input logic [uart_pkg::addr_w-1:0] addr,
                           output logic [uart_pkg::data_w-1:0] rd);
      bus_cycle(addr, '0, 1'b0, rd);
   endtask

   // read a flag register until bit 0 matches
   task automatic poll_flag(input logic [uart_pkg::addr_w-1:0] addr, input logic value,
                            input string what);
      logic [uart_pkg::data_w-1:0] rd;
      int                          n;
      n = 0;
      bus_read(addr, rd);
      while (rd[0] !== value && n < poll_limit) begin
         bus_read(addr, rd);
         n++;
      end
      if (rd[0] !== value) begin
         other_errs++;
         $display("%s never read %0d within %0d polls", what, value, poll_limit);
      end
   endtask

   // start, data LSB first, stop
   task automatic send_frame(input logic [uart_pkg::byte_w-1:0] b);
      logic [9:0] bits;
      int         i;
      bits = {1'b1, b, 1'b0};
      for (i = 0; i < 10; i++) begin
         @(posedge clk);
         rxd <= bits[i];
         if (i == 1) begin
            @(negedge clk);
            check_bit("rts", 1'b0, rts);
         end
         repeat (div_test - 1) @(posedge clk);
      end
   endtask

   task automatic capture_frame(output logic [uart_pkg::byte_w-1:0] got);
      int n;
      int i;
      n   = 0;
      got = '0;
      while (txd !== 1'b0 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (txd !== 1'b0) begin
         other_errs++;
         $display("no start bit appeared on txd after the data write");
      end else begin
         // move to the centre of the start bit
         repeat (div_test / 2) @(negedge clk);
         check_bit("txd start", 1'b0, txd);
         for (i = 0; i < uart_pkg::byte_w; i++) begin
            repeat (div_test) @(negedge clk);
            got[i] = txd;
         end
         repeat (div_test) @(negedge clk);
         check_bit("txd stop", 1'b1, txd);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_defaults();
      logic [uart_pkg::data_w-1:0] rd;
      bus_read(uart_pkg::addr_div, rd);
      check_word("divider", 32'd1, rd);
      bus_read(uart_pkg::addr_read_valid, rd);
      check_word("read_valid", 32'd0, rd);
      bus_read(uart_pkg::addr_write_wait, rd);
      check_word("write_wait", 32'd0, rd);
      check_bit("txd", 1'b1, txd);
      check_bit("rts", 1'b0, rts);
   endtask

   task automatic divider_and_enables();
      logic [uart_pkg::data_w-1:0] rd;
      bus_write(uart_pkg::addr_div, div_test);
      bus_read(uart_pkg::addr_div, rd);
      check_word("divider", div_test, rd);
      bus_write(uart_pkg::addr_rx_en, 32'd1);
      check_bit("rts", 1'b1, rts);
      // cts drops in the valid cycle and two flops hide it from this read
      fork
         begin
            @(posedge clk);
            cts <= 1'b0;
         end
         bus_read(uart_pkg::addr_write_wait, rd);
      join
      check_word("write_wait", 32'd0, rd);
      @(posedge clk);
      cts <= 1'b1;
      poll_flag(uart_pkg::addr_write_wait, 1'b0, "write_wait");
      // one cycle earlier the second flop holds it by the ready cycle
      @(posedge clk);
      cts <= 1'b0;
      bus_read(uart_pkg::addr_write_wait, rd);
      check_word("write_wait", 32'd1, rd);
      @(posedge clk);
      cts <= 1'b1;
      poll_flag(uart_pkg::addr_write_wait, 1'b0, "write_wait");
   endtask

   task automatic transmit_frames();
      logic [uart_pkg::byte_w-1:0] b, got;
      logic [uart_pkg::data_w-1:0] rd;
      bus_write(uart_pkg::addr_tx_en, 32'd1);
      repeat (4) begin
         poll_flag(uart_pkg::addr_write_wait, 1'b0, "write_wait");
         b = $random(seed);
         fork
            bus_write(uart_pkg::addr_data, {23'd0, b, 1'b0});
            capture_frame(got);
         join
         check_byte("txd byte", b, got);
         // stop bit still running
         bus_read(uart_pkg::addr_write_wait, rd);
         check_word("write_wait", 32'd1, rd);
      end
      poll_flag(uart_pkg::addr_write_wait, 1'b0, "write_wait");
   endtask

   task automatic transmit_disabled();
      logic line_high;
      bus_write(uart_pkg::addr_tx_en, 32'd0);
      line_high = 1'b1;
      fork
         bus_write(uart_pkg::addr_data, {23'd0, 8'h00, 1'b0});
         repeat (10 * div_test + 2) begin
            @(negedge clk);
            line_high = line_high && (txd === 1'b1);
         end
      join
      check_bit("txd disabled", 1'b1, line_high);
      poll_flag(uart_pkg::addr_write_wait, 1'b0, "write_wait");
   endtask

   task automatic receive_frames();
      logic [uart_pkg::byte_w-1:0] b;
      logic [uart_pkg::data_w-1:0] rd;
      repeat (4) begin
         b = $random(seed);
         send_frame(b);
         poll_flag(uart_pkg::addr_read_valid, 1'b1, "read_valid");
         bus_read(uart_pkg::addr_data, rd);
         check_word("rx data", {24'd0, b}, rd);
         bus_read(uart_pkg::addr_read_valid, rd);
         check_word("read_valid", 32'd0, rd);
         check_bit("rts", 1'b1, rts);
      end
   endtask

   task automatic soft_reset_clears();
      logic [uart_pkg::data_w-1:0] rd;
      bus_write(uart_pkg::addr_tx_en, 32'd1);
      send_frame($random(seed));
      poll_flag(uart_pkg::addr_read_valid, 1'b1, "read_valid");
      bus_write(uart_pkg::addr_soft_reset, 32'd1);
      bus_read(uart_pkg::addr_div, rd);
      check_word("divider", 32'd1, rd);
      check_bit("rts", 1'b0, rts);
      bus_read(uart_pkg::addr_read_valid, rd);
      check_word("read_valid", 32'd0, rd);
      // a cleared tx_en keeps the start bit off the line
      bus_write(uart_pkg::addr_data, {23'd0, 8'h00, 1'b0});
      check_bit("txd", 1'b1, txd);
   endtask

   initial begin
      rst_int = 1'b1;
      valid   = 1'b0;
      address = '0;
      wdata   = '0;
      wstrb   = 1'b0;
      rxd     = 1'b1;
      cts     = 1'b1;
      repeat (2) @(posedge clk);
      rst_int <= 1'b0;
      reset_defaults();
      divider_and_enables();
      transmit_frames();
      transmit_disabled();
      receive_frames();
      soft_reset_clears();
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: uart_top.f
hw/uart_pkg.sv
hw/uart_link_if.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
testbench/uart_tb.sv
